/* verilog/routerPkg.sv */
package routerPkg;

  //////////////////////////////////////////////////////////////////////
  // port numbering and flit fields
  //////////////////////////////////////////////////////////////////////

  localparam int numPorts = 5;               // L, N, E, W, S

  typedef logic [2:0]  portIdxT;             // L=0 N=1 E=2 W=3 S=4
  typedef logic [2:0]  flitIdT;
  typedef logic [11:0] pktLenT;              // hold time in clk cycles

  localparam flitIdT headFlit = 3'd1;        // head flit carries the length

  //////////////////////////////////////////////////////////////////////
  // switch arbiter states
  //////////////////////////////////////////////////////////////////////

  // each port state sits one above its port index
  typedef enum logic [2:0] {
    stIdle  = 3'd0,
    stLocal = 3'd1,
    stNorth = 3'd2,
    stEast  = 3'd3,
    stWest  = 3'd4,
    stSouth = 3'd5
  } arbStateT;

endpackage

/* verilog/grantIf.sv */
`timescale 1ns/1ps

interface grantIf;
  import routerPkg::*;

  logic     granted;                         // output owned this cycle
  portIdxT  grantPort;                       // current holder
  logic     grantStart;                      // first cycle of a new grant
  arbStateT state;

  modport arb (
    output granted,
    output grantPort,
    output grantStart,
    output state
  );

  modport xbar (
    input granted,
    input grantPort,
    input grantStart,
    input state
  );

endinterface

/* verilog/holdTimer.sv */
`timescale 1ns/1ps

module holdTimer (
  input  logic              clk,
  input  logic              rst,
  input  routerPkg::flitIdT flitId,
  input  routerPkg::pktLenT length,
  input  logic              run,
  output logic              timesUp
);
  import routerPkg::*;

  pktLenT count;
  pktLenT limit;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
      limit <= '0;
    end
    else
    begin
      if (flitId == headFlit)
        limit <= length;                     // packet length from head flit
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;                         // restart for the next grant
    end
  end

  // goes high in the last cycle of the hold window
  assign timesUp = (count == limit);

endmodule

/* verilog/switchArbiter.sv */
`timescale 1ns/1ps

module switchArbiter (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic [routerPkg::numPorts-1:0]               reqs,
  input  routerPkg::flitIdT [routerPkg::numPorts-1:0]  flitIds,
  input  routerPkg::pktLenT [routerPkg::numPorts-1:0]  lengths,
  grantIf.arb                                          gnt,
  output logic [routerPkg::numPorts-1:0]               grants
);
  import routerPkg::*;

  arbStateT            state;
  arbStateT            nextState;
  portIdxT             holder;
  logic                granted;
  logic [numPorts-1:0] runTimer;
  logic [numPorts-1:0] timesUp;

  // state that grants a given port
  function automatic arbStateT portState(input int idx);
    return arbStateT'(idx + 1);
  endfunction

  // first requester in cyclic order from port first, looking at span ports
  function automatic arbStateT pickNext(
    input logic [numPorts-1:0] r,
    input int                  first,
    input int                  span
  );
    arbStateT pick;
    int       idx;
    pick = stIdle;
    for (int i = span - 1; i >= 0; i--)
    begin
      idx = (first + i) % numPorts;
      if (r[idx])
        pick = portState(idx);               // nearest requester wins
    end
    return pick;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // hold timers
  //////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < numPorts; p++)
  begin : genTimer
    assign runTimer[p] = (state == portState(p)) && reqs[p] && !timesUp[p];

    holdTimer timer (
      .clk     (clk),
      .rst     (rst),
      .flitId  (flitIds[p]),
      .length  (lengths[p]),
      .run     (runTimer[p]),
      .timesUp (timesUp[p])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // grant state machine
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (state)
      stLocal: holder = 3'd0;
      stNorth: holder = 3'd1;
      stEast:  holder = 3'd2;
      stWest:  holder = 3'd3;
      stSouth: holder = 3'd4;
      default: holder = 3'd0;
    endcase
  end

  assign granted = (state != stIdle);

  always_comb
  begin
    nextState = stIdle;
    if (!granted)
      nextState = pickNext(reqs, 0, numPorts);   // fixed priority, L first
    else if (reqs[holder] && !timesUp[holder])
      nextState = state;                          // keep the grant
    else
      nextState = pickNext(reqs, int'(holder) + 1, numPorts - 1);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state          <= stIdle;
      gnt.grantStart <= 1'b0;
    end
    else
    begin
      state          <= nextState;
      gnt.grantStart <= (nextState != stIdle) && (nextState != state);
    end
  end

  // one-hot view of the holder
  always_comb
  begin
    grants = '0;
    if (granted)
      grants[holder] = 1'b1;
  end

  assign gnt.state     = state;
  assign gnt.granted   = granted;
  assign gnt.grantPort = holder;

endmodule

/* verilog/flitCrossbar.sv */
`timescale 1ns/1ps

module flitCrossbar #(
  parameter int dataWidth = 32
) (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic [routerPkg::numPorts-1:0][dataWidth-1:0] datas,
  grantIf.xbar                                        gnt,
  output routerPkg::portIdxT                          outPort,
  output logic                                        outValid,
  output logic [dataWidth-1:0]                        outData
);
  import routerPkg::*;

  logic [dataWidth-1:0] selData;

  //////////////////////////////////////////////////////////////////////
  // five-to-one select
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (gnt.grantPort)
      3'd0:    selData = datas[0];           // local
      3'd1:    selData = datas[1];
      3'd2:    selData = datas[2];
      3'd3:    selData = datas[3];
      3'd4:    selData = datas[4];
      default: selData = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // output link register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outPort  <= '0;
    end
    else
    begin
      outValid <= (gnt.state != stIdle);
      if (gnt.grantStart)
        outPort <= gnt.grantPort;            // holder only changes here
    end
  end

  always_ff @(posedge clk)
  begin
    if (gnt.granted)
      outData <= selData;
  end

endmodule

/* verilog/routerOutputPort.sv */
`timescale 1ns/1ps

module routerOutputPort #(
  parameter int dataWidth = 32
) (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic [routerPkg::numPorts-1:0]                reqs,
  input  routerPkg::flitIdT [routerPkg::numPorts-1:0]   flitIds,
  input  routerPkg::pktLenT [routerPkg::numPorts-1:0]   lengths,
  input  logic [routerPkg::numPorts-1:0][dataWidth-1:0] datas,
  output logic [routerPkg::numPorts-1:0]                grants,
  output routerPkg::portIdxT                            outPort,
  output logic                                          outValid,
  output logic [dataWidth-1:0]                          outData
);

  //////////////////////////////////////////////////////////////////////
  // arbiter decision shared with the crossbar
  //////////////////////////////////////////////////////////////////////

  grantIf gnt ();

  // requests, ids and lengths feed the arbiter
  switchArbiter arbiter (
    .clk     (clk),
    .rst     (rst),
    .reqs    (reqs),
    .flitIds (flitIds),
    .lengths (lengths),
    .gnt     (gnt.arb),
    .grants  (grants)
  );

  // data words go straight to the crossbar
  flitCrossbar #(
    .dataWidth (dataWidth)
  ) crossbar (
    .clk      (clk),
    .rst      (rst),
    .datas    (datas),
    .gnt      (gnt.xbar),
    .outPort  (outPort),
    .outValid (outValid),
    .outData  (outData)
  );

endmodule

/* test/routerOutputPortTb.sv */
`timescale 1ns/1ps

module routerOutputPortTb;
  import routerPkg::*;

  localparam int dataWidth = 32;
  localparam int maxSteps  = 32;

  logic                               clk;
  logic                               rst;
  logic [numPorts-1:0]                reqs;
  flitIdT [numPorts-1:0]              flitIds;
  pktLenT [numPorts-1:0]              lengths;
  logic [numPorts-1:0][dataWidth-1:0] datas;
  logic [numPorts-1:0]                grants;
  portIdxT                            outPort;
  logic                               outValid;
  logic [dataWidth-1:0]               outData;

  int          numSteps;
  int          stepTest [maxSteps];
  logic [4:0]  stepMask [maxSteps];
  int          stepHead [maxSteps];
  int          stepLen [maxSteps][numPorts];
  int          stepCycles [maxSteps];
  logic [31:0] stepOrder [maxSteps];           // one nibble per new holder, index+1

  int                   refHolder;             // -1 while idle
  int                   refCount;
  int                   refLimit [numPorts];
  logic                 expValid;
  int                   expPort;
  logic [dataWidth-1:0] expData;

  logic [31:0]          seed;
  logic [numPorts-1:0]  lastGrants;
  int                   cycleCount;
  int                   cycleLimit;
  int                   testErrors;
  int                   totalErrors;
  int                   testsPassed;
  int                   testsFailed;

  routerOutputPort #(
    .dataWidth (dataWidth)
  ) UUT (
    .clk      (clk),
    .rst      (rst),
    .reqs     (reqs),
    .flitIds  (flitIds),
    .lengths  (lengths),
    .datas    (datas),
    .grants   (grants),
    .outPort  (outPort),
    .outValid (outValid),
    .outData  (outData)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic int holderOf(input logic [numPorts-1:0] g);
    int idx;
    idx = -1;
    for (int p = 0; p < numPorts; p++)
      if (g[p])
        idx = p;
    return idx;
  endfunction

  task automatic logMismatch(input string name, input logic [31:0] expV, input logic [31:0] gotV);
    $display("[FAIL] %0t ns  %s expected %0h got %0h", $time, name, expV, gotV);
    testErrors++;
  endtask

  task automatic loadVectors();
    int          fd;
    int          code;
    int          t;
    int          h;
    int          c;
    int          len [numPorts];
    logic [31:0] m;
    logic [31:0] ord;
    string       line;
    numSteps   = 0;
    cycleLimit = 0;
    fd = $fopen("test/arbiterVectors.txt", "r");
    if (fd == 0)
      $display("cannot open test/arbiterVectors.txt for reading");
    else
    begin
      while (!$feof(fd) && numSteps < maxSteps)
      begin
        code = $fgets(line, fd);
        if (code != 0 && $sscanf(line, "%d %h %d %d %d %d %d %d %d %h", t, m, h,
                                 len[0], len[1], len[2], len[3], len[4], c, ord) == 10)
        begin
          stepTest[numSteps]   = t;
          stepMask[numSteps]   = m[4:0];
          stepHead[numSteps]   = h;
          stepLen[numSteps]    = len;
          stepCycles[numSteps] = c;
          stepOrder[numSteps]  = ord;
          numSteps++;
          cycleLimit += c;
        end
      end
      $fclose(fd);
      cycleLimit += 200;                       // reset and drain margin
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model, one call per rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic advanceModel();
    int nextHolder;
    int base;
    int first;
    nextHolder = refHolder;
    expValid   = (refHolder >= 0);
    if (refHolder >= 0)
    begin
      expPort = refHolder;                     // link takes the holder's word
      expData = datas[refHolder];
    end
    if (refHolder < 0 || !reqs[refHolder] || refCount == refLimit[refHolder])
    begin
      nextHolder = -1;
      base       = (refHolder < 0) ? 0 : refHolder;
      first      = (refHolder < 0) ? 0 : 1;    // from idle L is looked at first
      for (int k = first; k < numPorts; k++)
        if (nextHolder < 0 && reqs[(base + k) % numPorts])
          nextHolder = (base + k) % numPorts;
      refCount = 0;
    end
    else
      refCount++;
    for (int p = 0; p < numPorts; p++)
      if (flitIds[p] == headFlit)
        refLimit[p] = lengths[p];
    refHolder = nextHolder;
  endtask

  task automatic driveStep(input int s, input bit first);
    for (int p = 0; p < numPorts; p++)
    begin
      seed = lcgNext(seed);
      reqs[p]    <= stepMask[s][p];
      flitIds[p] <= (first && stepHead[s] != 0 && stepMask[s][p]) ? headFlit : flitIdT'(0);
      lengths[p] <= pktLenT'(stepLen[s][p]);
      datas[p]   <= seed;
    end
  endtask

  task automatic checkOutputs();
    logic [numPorts-1:0] expGrants;
    expGrants = '0;
    if (refHolder >= 0)
      expGrants[refHolder] = 1'b1;
    assert (grants === expGrants) else logMismatch("grants", expGrants, grants);
    assert (outValid === expValid) else logMismatch("outValid", expValid, outValid);
    if (expValid)
    begin
      assert (outPort === portIdxT'(expPort)) else logMismatch("outPort", expPort, outPort);
      assert (outData === expData) else logMismatch("outData", expData, outData);
    end
  endtask

  task automatic runStep(input int s);
    logic [31:0] order;
    order = '0;
    for (int c = 0; c < stepCycles[s]; c++)
    begin
      @(posedge clk);
      advanceModel();
      driveStep(s, c == 0);
      @(negedge clk);
      checkOutputs();
      if (grants != '0 && grants != lastGrants)
        order = (order << 4) | (holderOf(grants) + 1);   // a new holder
      lastGrants = grants;
    end
    assert (order == stepOrder[s]) else logMismatch("grant order", stepOrder[s], order);
  endtask

  task automatic finishTest(input int id);
    if (testErrors == 0)
    begin
      testsPassed++;
      $display("test %0d: ok", id);
    end
    else
    begin
      testsFailed++;
      $display("test %0d: %0d mismatches", id, testErrors);
    end
    totalErrors += testErrors;
    testErrors = 0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int curTest;
    rst         = 1'b1;
    reqs        = '0;
    flitIds     = '0;
    lengths     = '0;
    datas       = '0;
    seed        = 32'd88216;
    lastGrants  = '0;
    refHolder   = -1;
    refCount    = 0;
    refLimit    = '{default: 0};
    testErrors  = 0;
    totalErrors = 0;
    testsPassed = 0;
    testsFailed = 0;
    loadVectors();
    if (numSteps == 0)
    begin
      $display("no stimulus steps could be read, nothing was tested");
      $display("Simulation FAILED");
    end
    else
    begin
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      curTest = stepTest[0];
      for (int s = 0; s < numSteps; s++)
      begin
        if (stepTest[s] != curTest)
        begin
          finishTest(curTest);
          curTest = stepTest[s];
        end
        runStep(s);
      end
      finishTest(curTest);
      $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
               testsPassed + testsFailed, testsPassed, testsFailed, totalErrors);
      if (testsFailed == 0)
        $display("Simulation PASSED");
      else
        $display("Simulation FAILED");
    end
    $finish;
  end

  initial
  begin
    cycleCount = 0;
    @(posedge clk);
    while (cycleLimit == 0 || cycleCount < cycleLimit)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: the tests did not finish within %0d clock cycles", cycleLimit);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* test/arbiterVectors.txt */
# test mask(hex) head len0 len1 len2 len3 len4 cycles order(hex)
# head=1 puts a head flit on every requesting port in the first cycle of the step
# order: ports (index+1) that newly win the grant during the step, oldest first
# 1 reset, no requests
1 00 0 0 0 0 0 0 4 0
# 2 idle priority from N, W, S raised together
2 1a 1 0 1 0 0 2 6 245
2 00 0 0 0 0 0 0 3 0
# 3 timeout, E alone with length 3
3 04 1 0 0 3 0 0 12 333
3 00 0 0 0 0 0 0 3 0
# 4 round robin with all five requesting
4 1f 1 0 1 0 2 1 14 12345123
# 5 early release, W drops, then all drop, then L drops a long packet
5 17 0 0 0 0 0 0 4 451
5 00 0 0 0 0 0 0 3 2
5 01 1 20 0 0 0 0 4 1
5 08 0 0 0 0 0 0 4 4
5 00 0 0 0 0 0 0 3 0
# 6 data path, N and S alternate with length 3
6 12 1 0 3 0 0 3 10 252
6 00 0 0 0 0 0 0 4 0

/* sources.f */
verilog/routerPkg.sv
verilog/grantIf.sv
verilog/holdTimer.sv
verilog/switchArbiter.sv
verilog/flitCrossbar.sv
verilog/routerOutputPort.sv
test/routerOutputPortTb.sv

/* runSim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module routerOutputPortTb -f sources.f \
  --Mdir obj_dir -o simv

./obj_dir/simv 2>&1 | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "runSim: simulation reported failure"
  exit 1
fi
echo "runSim: done"
